// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb import isa_pkg::*; ();
	logic                  clk;
	logic                  rst_n;
	logic                  run;
	logic                  boot_we;
	logic [mem_addr_w-1:0] boot_addr;
	logic [word_w-1:0]     boot_data;
	logic                  commit_valid;
	logic                  commit_we;
	logic [reg_addr_w-1:0] commit_reg;
	logic [word_w-1:0]     commit_data;
	logic [word_w-1:0]     retired;
	logic                  halted;

	// Program image and the expected commit stream
	logic [word_w-1:0]     prog [$];
	logic                  exp_we [$];
	logic [reg_addr_w-1:0] exp_reg [$];
	logic [word_w-1:0]     exp_data [$];
	logic [word_w-1:0]     model_mem [dmem_depth];
	logic                  halted_seen;
	integer                seed;
	int                    checks;
	int                    errors;
	int                    timeouts;
	int                    commits;

	cpu_top u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.run          (run),
		.boot_we      (boot_we),
		.boot_addr    (boot_addr),
		.boot_data    (boot_data),
		.commit_valid (commit_valid),
		.commit_we    (commit_we),
		.commit_reg   (commit_reg),
		.commit_data  (commit_data),
		.retired      (retired),
		.halted       (halted)
	);

	always #10 clk = ~clk;

	function automatic logic [word_w-1:0] reg_op(input logic [op_w-1:0] op, input int rd,
			input int rs, input int rt);
		logic [word_w-1:0] w;
		w = '0;
		w[op_msb:op_lsb] = op;
		w[rd_msb:rd_lsb] = rd[reg_addr_w-1:0];
		w[rs_msb:rs_lsb] = rs[reg_addr_w-1:0];
		w[rt_msb:rt_lsb] = rt[reg_addr_w-1:0];
		return w;
	endfunction

	function automatic logic [word_w-1:0] imm_op(input logic [op_w-1:0] op, input int rd,
			input int rs, input int imm);
		logic [word_w-1:0] w;
		w = '0;
		w[op_msb:op_lsb]     = op;
		w[rd_msb:rd_lsb]     = rd[reg_addr_w-1:0];
		w[rs_msb:rs_lsb]     = rs[reg_addr_w-1:0];
		w[imm6_msb:imm6_lsb] = imm[imm6_w-1:0];
		return w;
	endfunction

	function automatic logic [word_w-1:0] li_op(input int rd, input int imm);
		logic [word_w-1:0] w;
		w = '0;
		w[op_msb:op_lsb]     = op_li;
		w[rd_msb:rd_lsb]     = rd[reg_addr_w-1:0];
		w[imm8_msb:imm8_lsb] = imm[imm8_w-1:0];
		return w;
	endfunction

	function automatic int rand_bits(input int mask);
		integer r;
		r = $random(seed);
		return r & mask;
	endfunction

	task automatic expect_equal(input string name, input logic [word_w-1:0] got,
			input logic [word_w-1:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, want);
		end
	endtask

	task automatic check_commit();
		logic                  want_we;
		logic [reg_addr_w-1:0] want_reg;
		logic [word_w-1:0]     want_data;

		commits++;
		if (exp_we.size() == 0) begin
			errors++;
			$display("Commit to r%0d arrived after the program should have ended", commit_reg);
		end else begin
			want_we   = exp_we.pop_front();
			want_reg  = exp_reg.pop_front();
			want_data = exp_data.pop_front();
			expect_equal("commit_we", word_w'(commit_we), word_w'(want_we));
			// Reg and data only matter for a write
			if (want_we) begin
				expect_equal("commit_reg", word_w'(commit_reg), word_w'(want_reg));
				expect_equal("commit_data", commit_data, want_data);
			end
		end
	endtask

	// Outputs are looked at on the falling edge, inputs change on the rising one
	task automatic next_cycle();
		@(negedge clk);
		halted_seen = halted;
		if (rst_n && commit_valid)
			check_commit();
		@(posedge clk);
	endtask

	task automatic apply_reset();
		next_cycle();
		run   <= 1'b0;
		rst_n <= 1'b0;
		repeat (4) next_cycle();
		rst_n <= 1'b1;
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size() + 4; i++) begin
			next_cycle();
			boot_we   <= 1'b1;
			boot_addr <= i[mem_addr_w-1:0];
			boot_data <= (i < prog.size()) ? prog[i] : '0;
		end
		next_cycle();
		boot_we <= 1'b0;
		run     <= 1'b1;
	endtask

	// Sequential interpreter of the ISA
	task automatic interpret(output int count);
		logic [word_w-1:0]     regs [reg_count];
		logic [word_w-1:0]     w;
		logic [word_w-1:0]     res;
		logic [word_w-1:0]     imm;
		logic [word_w-1:0]     addr;
		logic [op_w-1:0]       op;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic                  wr;
		logic                  done;
		int                    pc;
		int                    offset;

		foreach (regs[i])
			regs[i] = '0;
		exp_we.delete();
		exp_reg.delete();
		exp_data.delete();
		pc    = 0;
		count = 0;
		done  = 1'b0;
		// Step limit in case a program loops forever
		while (!done && count < 1000) begin
			w      = (pc < prog.size()) ? prog[pc] : '0;
			op     = w[op_msb:op_lsb];
			rd     = w[rd_msb:rd_lsb];
			rs     = w[rs_msb:rs_lsb];
			rt     = w[rt_msb:rt_lsb];
			offset = int'($signed(w[imm6_msb:imm6_lsb]));
			imm    = offset[word_w-1:0];
			addr   = regs[rs] + imm;
			res    = '0;
			pc     = (pc + 1) % imem_depth;
			count++;
			case (op)
				op_add:  res = regs[rs] + regs[rt];
				op_sub:  res = regs[rs] - regs[rt];
				op_and:  res = regs[rs] & regs[rt];
				op_or:   res = regs[rs] | regs[rt];
				op_xor:  res = regs[rs] ^ regs[rt];
				op_sll:  res = regs[rs] << w[shamt_w-1:0];
				op_addi: res = regs[rs] + imm;
				op_li:   res = word_w'(w[imm8_msb:imm8_lsb]);
				op_lw:   res = model_mem[addr[mem_addr_w-1:0]];
				op_sw:   model_mem[addr[mem_addr_w-1:0]] = regs[rd];
				op_beqz: begin
					if (regs[rd] == '0)
						pc = (pc + offset) & (imem_depth - 1);
				end
				op_halt: done = 1'b1;
				default: res = '0;
			endcase
			wr = op inside {op_add, op_sub, op_and, op_or, op_xor, op_sll, op_addi, op_li, op_lw};
			if (wr && rd != '0)
				regs[rd] = res;
			exp_we.push_back(wr && rd != '0);
			exp_reg.push_back(rd);
			exp_data.push_back(res);
		end
	endtask

	task automatic run_program(input string name);
		int count;
		int n;

		interpret(count);
		apply_reset();
		@(negedge clk);
		expect_equal("commit_valid", word_w'(commit_valid), '0);
		expect_equal("halted", word_w'(halted), '0);
		expect_equal("retired", retired, '0);
		@(posedge clk);
		load_program();

		n = 0;
		while (!halted_seen && n < 400) begin
			next_cycle();
			n++;
		end
		if (!halted_seen) begin
			timeouts++;
			$display("Program %s did not raise halted within %0d cycles", name, n);
		end
		n = 0;
		while (exp_we.size() != 0 && n < 10) begin
			next_cycle();
			n++;
		end
		if (exp_we.size() != 0) begin
			timeouts++;
			$display("Program %s still owes %0d commits", name, exp_we.size());
		end

		// Room for a stray commit to show up
		repeat (4) next_cycle();
		@(negedge clk);
		expect_equal("retired", retired, count[word_w-1:0]);
		expect_equal("halted", word_w'(halted), 16'h0001);
		@(posedge clk);
	endtask

	task automatic alu_program();
		int a_hi;
		int a_lo;
		int b_hi;
		int b_lo;

		a_hi = rand_bits(127) | 128;
		a_lo = rand_bits(255);
		b_hi = rand_bits(255);
		b_lo = rand_bits(255);
		prog.delete();
		prog.push_back(li_op(1, a_hi));
		prog.push_back(imm_op(op_sll, 1, 1, 8));
		prog.push_back(li_op(3, a_lo));
		prog.push_back(reg_op(op_or, 1, 1, 3));
		prog.push_back(li_op(2, b_hi));
		prog.push_back(imm_op(op_sll, 2, 2, 8));
		prog.push_back(li_op(3, b_lo));
		prog.push_back(reg_op(op_xor, 2, 2, 3));
		prog.push_back(reg_op(op_add, 4, 1, 2));
		prog.push_back(reg_op(op_sub, 5, 1, 2));
		prog.push_back(reg_op(op_sub, 6, 2, 1));
		prog.push_back(reg_op(op_and, 7, 1, 2));
		prog.push_back(reg_op(op_or, 3, 4, 5));
		prog.push_back(reg_op(op_xor, 4, 6, 7));
		prog.push_back(imm_op(op_sll, 5, 1, rand_bits(15)));
		prog.push_back(imm_op(op_addi, 6, 2, rand_bits(31) - 32));
		prog.push_back(imm_op(op_addi, 7, 0, rand_bits(63)));
		// r0 must stay zero
		prog.push_back(reg_op(op_add, 0, 1, 2));
		prog.push_back(reg_op(op_add, 3, 0, 0));
		prog.push_back(reg_op(op_or, 4, 0, 1));
		prog.push_back(reg_op(op_sub, 5, 0, 1));
		prog.push_back(reg_op(op_halt, 0, 0, 0));
	endtask

	task automatic memory_program();
		prog.delete();
		prog.push_back(li_op(1, 8'h40));
		prog.push_back(li_op(2, rand_bits(255)));
		prog.push_back(imm_op(op_sll, 2, 2, 4));
		prog.push_back(imm_op(op_sw, 2, 1, 0));
		prog.push_back(imm_op(op_lw, 3, 1, 0));
		// Load then use, no gap
		prog.push_back(reg_op(op_add, 4, 3, 3));
		prog.push_back(imm_op(op_sw, 4, 1, 1));
		prog.push_back(imm_op(op_lw, 5, 1, 1));
		prog.push_back('0);
		prog.push_back(imm_op(op_addi, 5, 5, -2));
		prog.push_back(imm_op(op_sw, 5, 1, -1));
		prog.push_back(li_op(6, 8'h3f));
		prog.push_back(imm_op(op_lw, 7, 6, 0));
		prog.push_back(imm_op(op_lw, 6, 1, 0));
		prog.push_back(reg_op(op_xor, 7, 7, 6));
		prog.push_back(imm_op(op_addi, 1, 1, 2));
		prog.push_back(imm_op(op_sw, 7, 1, 0));
		prog.push_back(imm_op(op_lw, 2, 1, 0));
		prog.push_back(reg_op(op_sub, 3, 2, 7));
		prog.push_back(reg_op(op_halt, 0, 0, 0));
	endtask

	task automatic branch_program();
		prog.delete();
		prog.push_back(li_op(1, 0));
		prog.push_back(li_op(2, 5));
		prog.push_back(imm_op(op_beqz, 1, 0, 2));
		prog.push_back(li_op(3, 8'h11));
		prog.push_back(li_op(4, 8'h22));
		prog.push_back(li_op(5, 8'h33));
		prog.push_back(imm_op(op_beqz, 2, 0, 2));
		prog.push_back(li_op(3, 8'h44));
		prog.push_back(li_op(4, 8'h55));
		// Countdown loop, exits through a forward branch
		prog.push_back(li_op(6, 3));
		prog.push_back(imm_op(op_addi, 6, 6, -1));
		prog.push_back(imm_op(op_beqz, 6, 0, 1));
		prog.push_back(imm_op(op_beqz, 0, 0, -3));
		prog.push_back(li_op(7, 8'h66));
		prog.push_back(reg_op(op_halt, 0, 0, 0));
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       <= 1'b0;
		run         <= 1'b0;
		boot_we     <= 1'b0;
		boot_addr   <= '0;
		boot_data   <= '0;
		halted_seen = 1'b0;
		seed        = 32'h6346;
		checks      = 0;
		errors      = 0;
		timeouts    = 0;
		commits     = 0;

		alu_program();
		run_program("alu");
		memory_program();
		run_program("memory");
		branch_program();
		run_program("branch");

		$display("Summary: %0d checks, %0d commits, %0d errors, %0d timeouts",
			checks, commits, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the cpu testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -f sim.f -o cpu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "Simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== sim.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/pipe_if.sv
source/fetch_unit.sv
source/reg_file.sv
source/decoder.sv
source/data_mem.sv
source/execute_stage.sv
source/writeback.sv
source/cpu_top.sv
bench/cpu_tb.sv

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import isa_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  run,
	input  logic                  boot_we,
	input  logic [mem_addr_w-1:0] boot_addr,
	input  logic [word_w-1:0]     boot_data,
	output logic                  commit_valid,
	output logic                  commit_we,
	output logic [reg_addr_w-1:0] commit_reg,
	output logic [word_w-1:0]     commit_data,
	output logic [word_w-1:0]     retired,
	output logic                  halted
);
	logic [word_w-1:0]     instr;
	logic [mem_addr_w-1:0] pc_next;
	logic                  f_valid;
	logic                  redirect;
	logic [mem_addr_w-1:0] target;
	logic                  kill;
	logic                  ex_we;
	logic [reg_addr_w-1:0] ex_rd;
	logic [word_w-1:0]     ex_result;
	logic [reg_addr_w-1:0] rs_addr;
	logic [reg_addr_w-1:0] rt_addr;
	logic [word_w-1:0]     rs_data;
	logic [word_w-1:0]     rt_data;
	logic                  wr_en;
	logic [reg_addr_w-1:0] wr_addr;
	logic [word_w-1:0]     wr_data;

	dec_exe_if dec_exe ();
	exe_wb_if  exe_wb ();

	assign kill = redirect | halted;

	// IF stage
	fetch_unit __fetch_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.boot_we   (boot_we),
		.boot_addr (boot_addr),
		.boot_data (boot_data),
		.redirect  (redirect),
		.target    (target),
		.halt      (halted),
		.instr     (instr),
		.pc_next   (pc_next),
		.f_valid   (f_valid)
	);

	// ID stage
	decoder __decoder (
		.clk       (clk),
		.rst_n     (rst_n),
		.instr     (instr),
		.pc_next   (pc_next),
		.f_valid   (f_valid),
		.kill      (kill),
		.ex_we     (ex_we),
		.ex_rd     (ex_rd),
		.ex_result (ex_result),
		.rs_addr   (rs_addr),
		.rt_addr   (rt_addr),
		.rs_data   (rs_data),
		.rt_data   (rt_data),
		.fwd       (exe_wb.fwd),
		.out       (dec_exe.dec)
	);

	reg_file __reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	// EXE stage
	execute_stage __execute_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.in        (dec_exe.exe),
		.out       (exe_wb.exe),
		.redirect  (redirect),
		.target    (target),
		.halt      (halted),
		.ex_we     (ex_we),
		.ex_rd     (ex_rd),
		.ex_result (ex_result)
	);

	// WB stage
	writeback __writeback (
		.clk          (clk),
		.rst_n        (rst_n),
		.in           (exe_wb.wb),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.commit_valid (commit_valid),
		.commit_we    (commit_we),
		.commit_reg   (commit_reg),
		.commit_data  (commit_data),
		.retired      (retired)
	);

endmodule

// ==== source/data_mem.sv ====
`timescale 1ns/1ps

module data_mem import isa_pkg::*; (
	input  logic                  clk,
	input  logic                  we,
	input  logic [mem_addr_w-1:0] addr,
	input  logic [word_w-1:0]     wdata,
	output logic [word_w-1:0]     rdata
);
	logic [word_w-1:0] mem [dmem_depth];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
	end

	// Read is same-cycle, so a load never stalls
	assign rdata = mem[addr];

endmodule

// ==== source/decoder.sv ====
`timescale 1ns/1ps

module decoder import isa_pkg::*, pipe_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [word_w-1:0]     instr,
	input  logic [mem_addr_w-1:0] pc_next,
	input  logic                  f_valid,
	input  logic                  kill,
	input  logic                  ex_we,
	input  logic [reg_addr_w-1:0] ex_rd,
	input  logic [word_w-1:0]     ex_result,
	output logic [reg_addr_w-1:0] rs_addr,
	output logic [reg_addr_w-1:0] rt_addr,
	input  logic [word_w-1:0]     rs_data,
	input  logic [word_w-1:0]     rt_data,
	exe_wb_if.fwd                 fwd,
	dec_exe_if.dec                out
);
	logic [op_w-1:0]       op;
	logic [reg_addr_w-1:0] rd;
	logic [word_w-1:0]     imm6_sx;
	logic [word_w-1:0]     imm8_zx;
	logic [word_w-1:0]     rs_val;
	logic [word_w-1:0]     rt_val;
	logic [word_w-1:0]     b_sel;
	ctrl_t                 ctrl;

	// Youngest producer wins
	function automatic logic [word_w-1:0] forward(input logic [reg_addr_w-1:0] addr,
			input logic [word_w-1:0] reg_val);
		if (addr == '0)
			return '0;
		if (ex_we && ex_rd == addr)
			return ex_result;
		if (fwd.we && fwd.rd == addr)
			return fwd.result;
		return reg_val;
	endfunction

	assign op      = instr[op_msb:op_lsb];
	assign rd      = instr[rd_msb:rd_lsb];
	assign rs_addr = instr[rs_msb:rs_lsb];
	// SW data and BEQZ test value come from rd
	assign rt_addr = (op == op_sw || op == op_beqz) ? rd : instr[rt_msb:rt_lsb];
	assign imm6_sx = {{(word_w - imm6_w){instr[imm6_msb]}}, instr[imm6_msb:imm6_lsb]};
	assign imm8_zx = {{(word_w - imm8_w){1'b0}}, instr[imm8_msb:imm8_lsb]};

	always_comb begin
		rs_val = forward(rs_addr, rs_data);
		rt_val = forward(rt_addr, rt_data);
	end

	always_comb begin
		ctrl  = ctrl_none;
		b_sel = imm6_sx;
		case (op)
			op_add, op_sub, op_and, op_or, op_xor: begin
				ctrl.reg_we = 1'b1;
				b_sel       = rt_val;
			end
			op_sll, op_addi: ctrl.reg_we = 1'b1;
			op_li: begin
				ctrl.reg_we = 1'b1;
				b_sel       = imm8_zx;
			end
			op_lw: begin
				ctrl.reg_we = 1'b1;
				ctrl.mem_rd = 1'b1;
			end
			op_sw:   ctrl.mem_wr    = 1'b1;
			op_beqz: ctrl.is_branch = 1'b1;
			op_halt: ctrl.is_halt   = 1'b1;
			default: ctrl           = ctrl_none;
		endcase
		case (op)
			op_sub:  ctrl.alu_op = alu_sub;
			op_and:  ctrl.alu_op = alu_and;
			op_or:   ctrl.alu_op = alu_or;
			op_xor:  ctrl.alu_op = alu_xor;
			op_sll:  ctrl.alu_op = alu_sll;
			op_nop, op_add, op_addi, op_lw, op_sw: ctrl.alu_op = alu_add;
			default: ctrl.alu_op = alu_pass_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			out.valid <= 1'b0;
		else
			out.valid <= f_valid & ~kill;
	end

	always_ff @(posedge clk) begin
		out.ctrl       <= ctrl;
		out.rd         <= rd;
		out.a          <= rs_val;
		out.b          <= b_sel;
		out.store_data <= rt_val;
		out.pc_next    <= pc_next;
	end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	dec_exe_if.exe                in,
	exe_wb_if.exe                 out,
	output logic                  redirect,
	output logic [mem_addr_w-1:0] target,
	output logic                  halt,
	output logic                  ex_we,
	output logic [reg_addr_w-1:0] ex_rd,
	output logic [word_w-1:0]     ex_result
);
	logic [word_w-1:0] alu_res;
	logic [word_w-1:0] mem_rdata;
	logic              taken;
	logic              halt_now;

	always_comb begin
		case (in.ctrl.alu_op)
			alu_add: alu_res = in.a + in.b;
			alu_sub: alu_res = in.a - in.b;
			alu_and: alu_res = in.a & in.b;
			alu_or:  alu_res = in.a | in.b;
			alu_xor: alu_res = in.a ^ in.b;
			alu_sll: alu_res = in.a << in.b[shamt_w-1:0];
			default: alu_res = in.b;
		endcase
	end

	// ALU sum is the load/store address
	data_mem __data_mem (
		.clk   (clk),
		.we    (in.valid & in.ctrl.mem_wr),
		.addr  (alu_res[mem_addr_w-1:0]),
		.wdata (in.store_data),
		.rdata (mem_rdata)
	);

	assign ex_result = in.ctrl.mem_rd ? mem_rdata : alu_res;
	assign ex_rd     = in.rd;
	assign ex_we     = in.valid & in.ctrl.reg_we & (in.rd != '0);

	assign taken    = in.valid & in.ctrl.is_branch & (in.store_data == '0);
	assign halt_now = in.valid & in.ctrl.is_halt;
	// HALT flushes the younger pair like a taken branch
	assign redirect = taken | halt_now;
	assign target   = in.pc_next + in.b[mem_addr_w-1:0];

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (!rst_n)
			halt <= 1'b0;
		else if (halt_now)
			halt <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out.valid <= 1'b0;
			out.we    <= 1'b0;
		end else begin
			out.valid <= in.valid;
			out.we    <= ex_we;
		end
	end

	always_ff @(posedge clk) begin
		out.rd     <= in.rd;
		out.result <= ex_result;
	end

endmodule

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import isa_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  run,
	input  logic                  boot_we,
	input  logic [mem_addr_w-1:0] boot_addr,
	input  logic [word_w-1:0]     boot_data,
	input  logic                  redirect,
	input  logic [mem_addr_w-1:0] target,
	input  logic                  halt,
	output logic [word_w-1:0]     instr,
	output logic [mem_addr_w-1:0] pc_next,
	output logic                  f_valid
);
	logic [word_w-1:0]     imem [imem_depth];
	logic [mem_addr_w-1:0] pc;
	logic                  active;

	assign active = run & ~halt & ~redirect;

	// Boot port, only while the core is held
	always_ff @(posedge clk) begin
		if (boot_we && !run)
			imem[boot_addr] <= boot_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc      <= '0;
			f_valid <= 1'b0;
		end else begin
			f_valid <= active;
			if (redirect && !halt)
				pc <= target;
			else if (active)
				pc <= pc + 1'b1;
		end
	end

	// Fetch/decode register
	always_ff @(posedge clk) begin
		if (active) begin
			instr   <= imem[pc];
			pc_next <= pc + 1'b1;
		end
	end

endmodule

// ==== source/isa_pkg.sv ====
package isa_pkg;

	// Datapath
	localparam int word_w     = 16;
	localparam int reg_count  = 8;
	localparam int reg_addr_w = 3;
	localparam int shamt_w    = 4;

	// Memories
	localparam int imem_depth = 256;
	localparam int dmem_depth = 256;
	localparam int mem_addr_w = 8;

	// Opcodes, NOP is the all-zero word
	localparam int op_w = 4;
	localparam logic [op_w-1:0] op_nop  = 4'h0;
	localparam logic [op_w-1:0] op_add  = 4'h1;
	localparam logic [op_w-1:0] op_sub  = 4'h2;
	localparam logic [op_w-1:0] op_and  = 4'h3;
	localparam logic [op_w-1:0] op_or   = 4'h4;
	localparam logic [op_w-1:0] op_xor  = 4'h5;
	localparam logic [op_w-1:0] op_sll  = 4'h6;
	localparam logic [op_w-1:0] op_addi = 4'h7;
	localparam logic [op_w-1:0] op_li   = 4'h8;
	localparam logic [op_w-1:0] op_lw   = 4'h9;
	localparam logic [op_w-1:0] op_sw   = 4'ha;
	localparam logic [op_w-1:0] op_beqz = 4'hb;
	localparam logic [op_w-1:0] op_halt = 4'hc;

	// Field positions
	localparam int op_msb   = 15;
	localparam int op_lsb   = 12;
	localparam int rd_msb   = 11;
	localparam int rd_lsb   = 9;
	localparam int rs_msb   = 8;
	localparam int rs_lsb   = 6;
	localparam int rt_msb   = 5;
	localparam int rt_lsb   = 3;
	localparam int imm6_msb = 5;
	localparam int imm6_lsb = 0;
	localparam int imm8_msb = 7;
	localparam int imm8_lsb = 0;
	localparam int imm6_w   = imm6_msb - imm6_lsb + 1;
	localparam int imm8_w   = imm8_msb - imm8_lsb + 1;

endpackage

// ==== source/pipe_if.sv ====
`timescale 1ns/1ps

// Decode to execute register
interface dec_exe_if import isa_pkg::*, pipe_pkg::*; ();
	logic                  valid;
	ctrl_t                 ctrl;
	logic [reg_addr_w-1:0] rd;
	logic [word_w-1:0]     a;
	logic [word_w-1:0]     b;
	logic [word_w-1:0]     store_data;
	logic [mem_addr_w-1:0] pc_next;

	modport dec (output valid, ctrl, rd, a, b, store_data, pc_next);
	modport exe (input valid, ctrl, rd, a, b, store_data, pc_next);
endinterface

// Execute to result register
interface exe_wb_if import isa_pkg::*; ();
	logic                  valid;
	logic                  we;
	logic [reg_addr_w-1:0] rd;
	logic [word_w-1:0]     result;

	modport exe (output valid, we, rd, result);
	modport wb  (input valid, we, rd, result);
	// Second forwarding source for decode
	modport fwd (input valid, we, rd, result);
endinterface

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_pass_b
	} alu_op_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic    reg_we;
		logic    mem_rd;
		logic    mem_wr;
		logic    is_branch;
		logic    is_halt;
	} ctrl_t;

	// Bubble, no side effects
	localparam ctrl_t ctrl_none = '{alu_add, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};

endpackage

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import isa_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  wr_en,
	input  logic [reg_addr_w-1:0] wr_addr,
	input  logic [word_w-1:0]     wr_data,
	input  logic [reg_addr_w-1:0] rs_addr,
	input  logic [reg_addr_w-1:0] rt_addr,
	output logic [word_w-1:0]     rs_data,
	output logic [word_w-1:0]     rt_data
);
	logic [word_w-1:0] regs [reg_count];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// r0 is hardwired zero
	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// ==== source/writeback.sv ====
`timescale 1ns/1ps

module writeback import isa_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	exe_wb_if.wb                  in,
	output logic                  wr_en,
	output logic [reg_addr_w-1:0] wr_addr,
	output logic [word_w-1:0]     wr_data,
	output logic                  commit_valid,
	output logic                  commit_we,
	output logic [reg_addr_w-1:0] commit_reg,
	output logic [word_w-1:0]     commit_data,
	output logic [word_w-1:0]     retired
);
	assign wr_en   = in.valid & in.we;
	assign wr_addr = in.rd;
	assign wr_data = in.result;

	// Commit port shows exactly what the register file takes
	assign commit_valid = in.valid;
	assign commit_we    = wr_en;
	assign commit_reg   = in.rd;
	assign commit_data  = in.result;

	always_ff @(posedge clk) begin
		if (!rst_n)
			retired <= '0;
		else if (in.valid)
			retired <= retired + 1'b1;
	end

endmodule
